//--- logic/lsu_cfg.svh
// Load/store unit sizing, shared by the package and the RTL
// The line size is tied to the 64-bit data path and must stay 8
// Tag width follows from the address, index and offset widths
// Array depth is always a full power of two of the index width

`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// Bytes per cache line
`define LSU_LINE_BYTES 8

// Byte offset bits within a line
`define LSU_OFFSET_WIDTH ($clog2(`LSU_LINE_BYTES))

// 64 lines
`define LSU_INDEX_WIDTH 6

// Physical byte address
`define LSU_ADDR_WIDTH 32

`define LSU_TAG_WIDTH (`LSU_ADDR_WIDTH - `LSU_INDEX_WIDTH - `LSU_OFFSET_WIDTH)

// Line address as seen by memory
`define LSU_MEM_LINE_ADDR_WIDTH (`LSU_ADDR_WIDTH - `LSU_OFFSET_WIDTH)

// Entries in the tag and data arrays, neither of which has a reset
`define LSU_ARRAY_DEPTH (1 << `LSU_INDEX_WIDTH)

`endif

//--- logic/lsuPkg.sv
// Types shared across the load/store unit
// Addresses are physical; there is no translation and no atomics
// Widths come from the sizing header

`include "lsu_cfg.svh"

package lsuPkg;

    typedef enum logic {
        commandLoad  = 1'b0,
        commandStore = 1'b1
    } lsuCommand;

    // Access width and extension of a load or store
    typedef enum logic [2:0] {
        typeByte             = 3'd0,
        typeHalfWord         = 3'd1,
        typeWord             = 3'd2,
        typeDoubleWord       = 3'd3,
        typeUnsignedByte     = 3'd4,
        typeUnsignedHalfWord = 3'd5,
        typeUnsignedWord     = 3'd6
    } loadStoreType;

    typedef logic [`LSU_LINE_BYTES*8-1:0] lineData;

    // One bit per byte lane of a line
    typedef logic [`LSU_LINE_BYTES-1:0] byteMask;

    // One tag array word
    typedef struct packed {
        logic                      valid;
        logic [`LSU_TAG_WIDTH-1:0] tag;
    } tagEntry;

endpackage

//--- logic/cacheArrayIf.sv
// Controller access to the tag and data arrays
// Read values belong to the index presented one cycle earlier
// sweepDone stays low while the valid bits are cleared after reset

`timescale 1ns/1ps
`include "lsu_cfg.svh"

interface cacheArrayIf;

    logic [`LSU_INDEX_WIDTH-1:0] index;
    logic                        tagWriteEnable;
    lsuPkg::tagEntry             tagWriteValue;
    lsuPkg::tagEntry             readTag;
    lsuPkg::byteMask             dataWriteMask;
    lsuPkg::lineData             dataWriteValue;
    lsuPkg::lineData             readData;
    logic                        sweepDone;

    modport controller (
        output index, tagWriteEnable, tagWriteValue, dataWriteMask, dataWriteValue,
        input  readTag, readData, sweepDone
    );

    modport arrays (
        input  index, tagWriteEnable, tagWriteValue, dataWriteMask, dataWriteValue,
        output readTag, readData, sweepDone
    );

endinterface

//--- logic/cacheArrays.sv
// Direct-mapped tag array and byte-banked data array
// One-cycle read; a read in a write cycle returns the new value
// After reset the valid bits are cleared by a sweep of every index,
// taking one cycle per line; no access may be made until sweepDone

`timescale 1ns/1ps
`include "lsu_cfg.svh"

module cacheArrays (
    input  logic            clk,
    input  logic            rst,
    cacheArrayIf.arrays     arrays
);
    localparam int Depth = `LSU_ARRAY_DEPTH;
    localparam int IndexWidth = `LSU_INDEX_WIDTH;
    localparam int LineBytes = `LSU_LINE_BYTES;

    lsuPkg::tagEntry tagMem [Depth];
    logic [7:0] dataMem [Depth][LineBytes];

    logic sweeping;
    logic [IndexWidth-1:0] sweepIndex;

    always_ff @(posedge clk) begin
        if (rst) begin
            sweeping <= 1'b1;
            sweepIndex <= '0;
        end else if (sweeping) begin
            sweepIndex <= sweepIndex + 1'b1;
            if (sweepIndex == IndexWidth'(Depth - 1)) begin
                sweeping <= 1'b0;
            end
        end
    end

    assign arrays.sweepDone = !sweeping;

    // Sweep owns the tag write port until it ends
    always_ff @(posedge clk) begin
        if (sweeping) begin
            tagMem[sweepIndex] <= '0;
        end else if (arrays.tagWriteEnable) begin
            tagMem[arrays.index] <= arrays.tagWriteValue;
        end
        arrays.readTag <= arrays.tagWriteEnable ? arrays.tagWriteValue : tagMem[arrays.index];
    end

    always_ff @(posedge clk) begin
        for (int b = 0; b < LineBytes; b++) begin
            if (arrays.dataWriteMask[b]) begin
                dataMem[arrays.index][b] <= arrays.dataWriteValue[b*8 +: 8];
                arrays.readData[b*8 +: 8] <= arrays.dataWriteValue[b*8 +: 8];
            end else begin
                arrays.readData[b*8 +: 8] <= dataMem[arrays.index][b];
            end
        end
    end

    // Controller must hold off tag writes during the sweep
    tagWriteLegal: assert property (@(posedge clk) disable iff (rst)
        arrays.tagWriteEnable |-> !sweeping);

endmodule

//--- logic/lsuDataAlign.sv
// Byte lane alignment between a cache line and a 64-bit value
// Purely combinational
// Bytes past the end of the line read as zero and are never written,
// so a misaligned access is cut at the line boundary

`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsuDataAlign (
    input  lsuPkg::lineData                alignLine,
    input  logic [`LSU_OFFSET_WIDTH-1:0]   alignOffset,
    input  lsuPkg::loadStoreType           alignType,
    input  logic [63:0]                    storeData,
    output logic [63:0]                    loadValue,
    output lsuPkg::lineData                storeLine,
    output lsuPkg::byteMask                storeMask
);
    logic [63:0] shifted;
    lsuPkg::byteMask widthMask;

    // Right-align the addressed bytes, zero fill from the top
    assign shifted = alignLine >> {alignOffset, 3'b000};

    always_comb begin
        unique case (alignType)
            lsuPkg::typeByte:             loadValue = {{56{shifted[7]}}, shifted[7:0]};
            lsuPkg::typeHalfWord:         loadValue = {{48{shifted[15]}}, shifted[15:0]};
            lsuPkg::typeWord:             loadValue = {{32{shifted[31]}}, shifted[31:0]};
            lsuPkg::typeDoubleWord:       loadValue = shifted;
            lsuPkg::typeUnsignedByte:     loadValue = {56'b0, shifted[7:0]};
            lsuPkg::typeUnsignedHalfWord: loadValue = {48'b0, shifted[15:0]};
            lsuPkg::typeUnsignedWord:     loadValue = {32'b0, shifted[31:0]};
            default:                      loadValue = '0;
        endcase
    end

    // Lanes touched by an access at offset zero
    always_comb begin
        unique case (alignType)
            lsuPkg::typeByte,
            lsuPkg::typeUnsignedByte:     widthMask = 8'b0000_0001;
            lsuPkg::typeHalfWord,
            lsuPkg::typeUnsignedHalfWord: widthMask = 8'b0000_0011;
            lsuPkg::typeWord,
            lsuPkg::typeUnsignedWord:     widthMask = 8'b0000_1111;
            lsuPkg::typeDoubleWord:       widthMask = 8'b1111_1111;
            default:                      widthMask = '0;
        endcase
    end

    // Upper bytes fall off the end of the line
    assign storeLine = storeData << {alignOffset, 3'b000};
    assign storeMask = widthMask << alignOffset;

endmodule

//--- logic/lsuControl.sv
// Request FSM of the load/store unit with hit check, refill and write-through
// One request at a time; reqReady only in idle once the tag sweep is done
// Load hit responds two cycles after acceptance; misses and stores wait on memory
// Response is a one-cycle pulse with no back-pressure
// Only one memory read is ever outstanding

`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsuControl (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 reqValid,
    output logic                                 reqReady,
    input  lsuPkg::lsuCommand                    reqCommand,
    input  lsuPkg::loadStoreType                 reqType,
    input  logic [`LSU_ADDR_WIDTH-1:0]           reqAddr,
    input  logic [63:0]                          reqStoreData,
    output logic                                 respValid,
    output logic [63:0]                          respData,
    output logic                                 memReqValid,
    input  logic                                 memReqReady,
    output logic                                 memWrite,
    output logic [`LSU_MEM_LINE_ADDR_WIDTH-1:0]  memLineAddr,
    output lsuPkg::lineData                      memWriteData,
    output lsuPkg::byteMask                      memWriteMask,
    input  logic                                 memRespValid,
    input  lsuPkg::lineData                      memReadData,
    cacheArrayIf.controller                      arrays,
    input  logic [63:0]                          loadValue,
    input  lsuPkg::lineData                      storeLine,
    input  lsuPkg::byteMask                      storeMask,
    output logic [`LSU_OFFSET_WIDTH-1:0]         alignOffset,
    output lsuPkg::loadStoreType                 alignType,
    output lsuPkg::lineData                      alignLine,
    output logic [63:0]                          alignStoreData
);
    localparam int IndexLsb = `LSU_OFFSET_WIDTH;
    localparam int TagLsb = IndexLsb + `LSU_INDEX_WIDTH;
    localparam int AddrMsb = `LSU_ADDR_WIDTH - 1;

    typedef enum logic [2:0] {
        stateIdle,
        stateLookup,
        stateRefillRequest,
        stateRefillWait,
        stateStoreWrite,
        stateWriteThrough
    } lsuState;

    lsuState state;
    lsuState nextState;

    lsuPkg::lsuCommand regCommand;
    lsuPkg::loadStoreType regType;
    logic [AddrMsb:0] regAddr;
    logic [63:0] regStoreData;

    logic accept;
    logic hit;
    logic loadDone;
    logic storeDone;
    logic refillWrite;

    assign reqReady = (state == stateIdle) && arrays.sweepDone;
    assign accept = reqValid && reqReady;

    // Tag read belongs to the index presented in the previous cycle
    assign hit = arrays.readTag.valid && (arrays.readTag.tag == regAddr[AddrMsb:TagLsb]);

    assign loadDone = (state == stateLookup) && hit && (regCommand == lsuPkg::commandLoad);
    assign storeDone = (state == stateWriteThrough) && memReqReady;
    assign refillWrite = (state == stateRefillWait) && memRespValid;

    always_comb begin
        nextState = state;
        unique case (state)
            stateIdle:          if (accept) nextState = stateLookup;
            stateLookup: begin
                if (!hit) begin
                    nextState = stateRefillRequest;
                end else if (regCommand == lsuPkg::commandStore) begin
                    nextState = stateStoreWrite;
                end else begin
                    nextState = stateIdle;
                end
            end
            stateRefillRequest: if (memReqReady) nextState = stateRefillWait;
            // Replay the lookup on the refilled line
            stateRefillWait:    if (memRespValid) nextState = stateLookup;
            stateStoreWrite:    nextState = stateWriteThrough;
            stateWriteThrough:  if (memReqReady) nextState = stateIdle;
            default:            nextState = stateIdle;
        endcase
    end

    // Idle reads at the incoming address so a hit is known one cycle later
    always_comb begin
        arrays.index = (state == stateIdle) ? reqAddr[TagLsb-1:IndexLsb]
                                            : regAddr[TagLsb-1:IndexLsb];
        arrays.tagWriteEnable = refillWrite;
        arrays.tagWriteValue = '{valid: 1'b1, tag: regAddr[AddrMsb:TagLsb]};
        arrays.dataWriteValue = (state == stateStoreWrite) ? storeLine : memReadData;
        if (refillWrite) begin
            arrays.dataWriteMask = '1;
        end else if (state == stateStoreWrite) begin
            arrays.dataWriteMask = storeMask;
        end else begin
            arrays.dataWriteMask = '0;
        end
    end

    assign memReqValid = (state == stateRefillRequest) || (state == stateWriteThrough);
    assign memWrite = (state == stateWriteThrough);
    assign memLineAddr = regAddr[AddrMsb:IndexLsb];
    assign memWriteData = storeLine;
    assign memWriteMask = memWrite ? storeMask : '0;

    assign alignOffset = regAddr[IndexLsb-1:0];
    assign alignType = regType;
    assign alignLine = arrays.readData;
    assign alignStoreData = regStoreData;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= stateIdle;
            regCommand <= lsuPkg::commandLoad;
            regType <= lsuPkg::typeDoubleWord;
            respValid <= 1'b0;
        end else begin
            state <= nextState;
            if (accept) begin
                regCommand <= reqCommand;
                regType <= reqType;
            end
            respValid <= loadDone || storeDone;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            regAddr <= reqAddr;
            regStoreData <= reqStoreData;
        end
        if (loadDone) begin
            respData <= loadValue;
        end else if (storeDone) begin
            respData <= '0;
        end
    end

    // Memory request is held with its address until accepted
    memReqHeld: assert property (@(posedge clk) disable iff (rst)
        memReqValid && !memReqReady |=> memReqValid && $stable(memWrite)
            && $stable(memLineAddr));

    respSingle: assert property (@(posedge clk) disable iff (rst)
        respValid |=> !respValid);

endmodule

//--- logic/loadStoreUnit.sv
// Load/store unit top level with a direct-mapped write-through data cache
// Physical addresses only; 8-byte lines, 64 lines
// All ports synchronous to clk; rst is synchronous, active high
// reqReady stays low for one cycle per line after reset while valid bits clear

`timescale 1ns/1ps
`include "lsu_cfg.svh"

module loadStoreUnit (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 reqValid,
    output logic                                 reqReady,
    input  lsuPkg::lsuCommand                    reqCommand,
    input  lsuPkg::loadStoreType                 reqType,
    input  logic [`LSU_ADDR_WIDTH-1:0]           reqAddr,
    input  logic [63:0]                          reqStoreData,
    output logic                                 respValid,
    output logic [63:0]                          respData,
    output logic                                 memReqValid,
    input  logic                                 memReqReady,
    output logic                                 memWrite,
    output logic [`LSU_MEM_LINE_ADDR_WIDTH-1:0]  memLineAddr,
    output lsuPkg::lineData                      memWriteData,
    output lsuPkg::byteMask                      memWriteMask,
    input  logic                                 memRespValid,
    input  lsuPkg::lineData                      memReadData
);
    logic [63:0] loadValue;
    lsuPkg::lineData storeLine;
    lsuPkg::byteMask storeMask;
    logic [`LSU_OFFSET_WIDTH-1:0] alignOffset;
    lsuPkg::loadStoreType alignType;
    lsuPkg::lineData alignLine;
    logic [63:0] alignStoreData;

    cacheArrayIf arrayBus ();

    lsuControl u_lsuControl (
        .clk, .rst,
        .reqValid, .reqReady, .reqCommand, .reqType, .reqAddr, .reqStoreData,
        .respValid, .respData,
        .memReqValid, .memReqReady, .memWrite, .memLineAddr,
        .memWriteData, .memWriteMask, .memRespValid, .memReadData,
        .arrays(arrayBus.controller),
        .loadValue, .storeLine, .storeMask,
        .alignOffset, .alignType, .alignLine, .alignStoreData
    );

    cacheArrays u_cacheArrays (
        .clk, .rst,
        .arrays(arrayBus.arrays)
    );

    lsuDataAlign u_lsuDataAlign (
        .alignLine, .alignOffset, .alignType,
        .storeData(alignStoreData),
        .loadValue, .storeLine, .storeMask
    );

endmodule

//--- tests/tbLoadStoreUnit.sv
// Testbench for the load/store unit
// Memory model answers with LFSR-chosen stalls and read delays
// Expected loads come from a byte-level shadow of memory
// Every request is started on a falling edge, one at a time

`timescale 1ns/1ps
`include "lsu_cfg.svh"

module tbLoadStoreUnit;
    localparam int Timeout = 200;
    localparam int LineAddrWidth = `LSU_MEM_LINE_ADDR_WIDTH;

    logic clk;
    logic rst;
    logic reqValid;
    logic reqReady;
    lsuPkg::lsuCommand reqCommand;
    lsuPkg::loadStoreType reqType;
    logic [`LSU_ADDR_WIDTH-1:0] reqAddr;
    logic [63:0] reqStoreData;
    logic respValid;
    logic [63:0] respData;
    logic memReqValid;
    logic memReqReady;
    logic memWrite;
    logic [LineAddrWidth-1:0] memLineAddr;
    lsuPkg::lineData memWriteData;
    lsuPkg::byteMask memWriteMask;
    logic memRespValid;
    lsuPkg::lineData memReadData;

    lsuPkg::lineData memLines [logic [LineAddrWidth-1:0]];
    logic [7:0] shadow [logic [31:0]];
    logic [63:0] expectedQueue [$];
    string testName;
    int errorCount;
    int checkCount;
    int readCount;
    int writeCount;
    logic [15:0] stimLfsr;
    logic [15:0] memLfsr;
    int stallLeft;
    logic requestSeen;
    logic readPending;
    int readDelay;
    logic [LineAddrWidth-1:0] readLine;
    lsuPkg::byteMask lastWriteMask;

    loadStoreUnit u_loadStoreUnit (.*);

    always #20 clk = ~clk;

    function automatic logic [15:0] galoisStep(logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
    endfunction

    task automatic takeBits(inout logic [15:0] state, input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            state = galoisStep(state);
            value[i] = state[0];
        end
    endtask

    // Initial memory contents, a function of every line address bit
    function automatic lsuPkg::lineData fillLine(logic [LineAddrWidth-1:0] lineAddr);
        logic [31:0] a;
        a = 32'(lineAddr);
        return {a ^ 32'hA5C3_0F96, a * 32'h9E37_79B1 + 32'h1234_5678};
    endfunction

    function automatic lsuPkg::lineData readMemLine(logic [LineAddrWidth-1:0] lineAddr);
        return memLines.exists(lineAddr) ? memLines[lineAddr] : fillLine(lineAddr);
    endfunction

    function automatic logic [7:0] shadowByte(logic [31:0] addr);
        lsuPkg::lineData line;
        if (shadow.exists(addr)) begin
            return shadow[addr];
        end
        line = fillLine(addr[31:3]);
        return line[addr[2:0]*8 +: 8];
    endfunction

    function automatic lsuPkg::lineData shadowLine(logic [LineAddrWidth-1:0] lineAddr);
        lsuPkg::lineData line;
        for (int b = 0; b < 8; b++) begin
            line[b*8 +: 8] = shadowByte({lineAddr, 3'(b)});
        end
        return line;
    endfunction

    function automatic int typeBytes(lsuPkg::loadStoreType t);
        case (t)
            lsuPkg::typeByte, lsuPkg::typeUnsignedByte:         return 1;
            lsuPkg::typeHalfWord, lsuPkg::typeUnsignedHalfWord: return 2;
            lsuPkg::typeWord, lsuPkg::typeUnsignedWord:         return 4;
            default:                                            return 8;
        endcase
    endfunction

    // Bytes past the end of the line count as zero
    function automatic logic [63:0] expectedLoad(logic [31:0] addr, lsuPkg::loadStoreType t);
        logic [63:0] value;
        int n;
        value = '0;
        n = typeBytes(t);
        for (int i = 0; i < n; i++) begin
            if (int'(addr[2:0]) + i < 8) begin
                value[i*8 +: 8] = shadowByte(addr + 32'(i));
            end
        end
        if (t < lsuPkg::typeUnsignedByte && n < 8 && value[n*8-1]) begin
            for (int i = n * 8; i < 64; i++) begin
                value[i] = 1'b1;
            end
        end
        return value;
    endfunction

    function automatic lsuPkg::byteMask expectedMask(logic [31:0] addr, lsuPkg::loadStoreType t);
        return 8'(((1 << typeBytes(t)) - 1) << int'(addr[2:0]));
    endfunction

    task automatic storeShadow(logic [31:0] addr, lsuPkg::loadStoreType t, logic [63:0] data);
        for (int i = 0; i < typeBytes(t); i++) begin
            if (int'(addr[2:0]) + i < 8) begin
                shadow[addr + 32'(i)] = data[i*8 +: 8];
            end
        end
    endtask

    task automatic checkValue(string name, logic [63:0] expected, logic [63:0] actual);
        checkCount++;
        if (expected !== actual) begin
            errorCount++;
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic abortRun(string reason);
        errorCount++;
        $display("ERROR: %s", reason);
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        $display("Simulation finished: FAIL");
        $finish;
    endtask

    // Apply a write or start a read for the request accepted at the next edge
    task automatic serveMemRequest();
        lsuPkg::lineData line;
        logic [31:0] draw;
        if (memWrite) begin
            line = readMemLine(memLineAddr);
            for (int b = 0; b < 8; b++) begin
                if (memWriteMask[b]) begin
                    line[b*8 +: 8] = memWriteData[b*8 +: 8];
                end
            end
            memLines[memLineAddr] = line;
            lastWriteMask = memWriteMask;
            writeCount++;
        end else begin
            if (readPending) begin
                abortRun("a second memory read was issued while one was outstanding");
            end
            takeBits(memLfsr, 2, draw);
            readPending = 1'b1;
            readLine = memLineAddr;
            readDelay = int'(draw) + 1;
            readCount++;
        end
    endtask

    always @(negedge clk) begin
        logic [31:0] draw;
        if (rst) begin
            memReqReady = 1'b0;
            memRespValid = 1'b0;
            readPending = 1'b0;
            requestSeen = 1'b0;
        end else begin
            memRespValid = 1'b0;
            if (readPending) begin
                readDelay--;
                if (readDelay == 0) begin
                    readPending = 1'b0;
                    memRespValid = 1'b1;
                    memReadData = readMemLine(readLine);
                end
            end
            // Handshake finished at the last rising edge
            if (memReqReady) begin
                memReqReady = 1'b0;
                requestSeen = 1'b0;
            end else if (memReqValid) begin
                if (!requestSeen) begin
                    requestSeen = 1'b1;
                    takeBits(memLfsr, 2, draw);
                    stallLeft = int'(draw);
                end
                if (stallLeft == 0) begin
                    memReqReady = 1'b1;
                    serveMemRequest();
                end else begin
                    stallLeft--;
                end
            end
        end
    end

    always @(negedge clk) begin
        if (!rst && respValid) begin
            if (expectedQueue.size() == 0) begin
                abortRun("respValid pulsed with no request outstanding");
            end else begin
                checkValue(testName, expectedQueue.pop_front(), respData);
            end
        end
    end

    task automatic runRequest(input lsuPkg::lsuCommand command, input lsuPkg::loadStoreType t,
                              input logic [31:0] addr, input logic [63:0] data,
                              output int latency, output int reads);
        int waited;
        int readsBefore;
        @(negedge clk);
        reqValid = 1'b1;
        reqCommand = command;
        reqType = t;
        reqAddr = addr;
        reqStoreData = data;
        waited = 0;
        while (!reqReady) begin
            @(negedge clk);
            waited++;
            if (waited > Timeout) begin
                abortRun("request was never accepted");
            end
        end
        readsBefore = readCount;
        if (command == lsuPkg::commandStore) begin
            storeShadow(addr, t, data);
            expectedQueue.push_back('0);
        end else begin
            expectedQueue.push_back(expectedLoad(addr, t));
        end
        @(negedge clk);
        reqValid = 1'b0;
        latency = 1;
        while (!respValid) begin
            if (reqReady) begin
                abortRun("reqReady rose before the response to the current request");
            end
            @(negedge clk);
            latency++;
            if (latency > Timeout) begin
                abortRun("no response to an accepted request");
            end
        end
        reads = readCount - readsBefore;
    endtask

    initial begin
        int latency;
        int reads;
        int waited;
        int writesBefore;
        logic [31:0] draw;
        logic [31:0] addr;
        logic [63:0] data;
        lsuPkg::loadStoreType t;
        clk = 1'b0;
        rst = 1'b1;
        reqValid = 1'b0;
        reqCommand = lsuPkg::commandLoad;
        reqType = lsuPkg::typeDoubleWord;
        reqAddr = '0;
        reqStoreData = '0;
        memReqReady = 1'b0;
        memRespValid = 1'b0;
        memReadData = '0;
        errorCount = 0;
        checkCount = 0;
        readCount = 0;
        writeCount = 0;
        stimLfsr = 16'd80;
        memLfsr = 16'd80;
        stallLeft = 0;
        requestSeen = 1'b0;
        readPending = 1'b0;
        readDelay = 0;
        lastWriteMask = '0;
        testName = "reset";
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Valid bit sweep runs before the first request can go in
        waited = 0;
        while (!reqReady) begin
            if (respValid || memReqValid) begin
                abortRun("respValid or memReqValid went high before any request");
            end
            @(negedge clk);
            waited++;
            if (waited > Timeout) begin
                abortRun("reqReady did not rise after reset");
            end
        end

        for (int ti = 0; ti < 7; ti++) begin
            for (int off = 0; off < 8; off++) begin
                t = lsuPkg::loadStoreType'(ti);
                addr = 32'h8000_1000 + 32'((ti * 8 + off) * 8 + off);
                testName = $sformatf("load type %0d offset %0d first", ti, off);
                runRequest(lsuPkg::commandLoad, t, addr, '0, latency, reads);
                checkValue({testName, " reads"}, 64'(1), 64'(reads));
                testName = $sformatf("load type %0d offset %0d repeat", ti, off);
                runRequest(lsuPkg::commandLoad, t, addr, '0, latency, reads);
                checkValue({testName, " reads"}, 64'(0), 64'(reads));
                checkValue({testName, " latency"}, 64'(2), 64'(latency));
            end
        end

        // Random stores over four lines, each followed by overlapping loads
        for (int i = 0; i < 40; i++) begin
            takeBits(stimLfsr, 5, draw);
            addr = 32'h0004_2000 + 32'(draw[4:0]);
            takeBits(stimLfsr, 3, draw);
            t = (draw[2:0] == 3'd7) ? lsuPkg::typeDoubleWord : lsuPkg::loadStoreType'(draw[2:0]);
            takeBits(stimLfsr, 32, draw);
            data[31:0] = draw;
            takeBits(stimLfsr, 32, draw);
            data[63:32] = draw;
            writesBefore = writeCount;
            testName = $sformatf("store %0d", i);
            runRequest(lsuPkg::commandStore, t, addr, data, latency, reads);
            checkValue({testName, " writes"}, 64'(1), 64'(writeCount - writesBefore));
            checkValue({testName, " line"}, shadowLine(addr[31:3]), readMemLine(addr[31:3]));
            checkValue({testName, " mask"}, 64'(expectedMask(addr, t)), 64'(lastWriteMask));
            testName = $sformatf("store %0d reload", i);
            runRequest(lsuPkg::commandLoad, t, addr, '0, latency, reads);
            testName = $sformatf("store %0d line load", i);
            runRequest(lsuPkg::commandLoad, lsuPkg::typeDoubleWord, {addr[31:3], 3'b000}, '0,
                       latency, reads);
            testName = $sformatf("store %0d neighbor byte", i);
            runRequest(lsuPkg::commandLoad, lsuPkg::typeByte, {addr[31:3], addr[2:0] + 3'd1}, '0,
                       latency, reads);
        end

        // Same index, different tags
        for (int i = 0; i < 8; i++) begin
            testName = $sformatf("conflict %0d", i);
            if (i % 2 == 0) begin
                runRequest(lsuPkg::commandLoad, lsuPkg::typeDoubleWord, 32'h0010_0018, '0,
                           latency, reads);
            end else begin
                runRequest(lsuPkg::commandLoad, lsuPkg::typeWord, 32'h0020_001C, '0,
                           latency, reads);
            end
            checkValue({testName, " reads"}, 64'(1), 64'(reads));
        end

        @(negedge clk);
        if (expectedQueue.size() != 0) begin
            errorCount++;
            $display("ERROR: %0d responses never arrived", expectedQueue.size());
        end
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- flist.f
+incdir+logic
logic/lsuPkg.sv
logic/cacheArrayIf.sv
logic/cacheArrays.sv
logic/lsuDataAlign.sv
logic/lsuControl.sv
logic/loadStoreUnit.sv
tests/tbLoadStoreUnit.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tbLoadStoreUnit
RTL_TOP    := loadStoreUnit
FLIST      := flist.f
BUILD_DIR  := obj_dir
LOG        := sim.log
FLAGS      := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only --timing -Wall
PASS_TEXT  := Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
